// ==== rtl/mem_pkg.sv ====
package mem_pkg;

    // field widths of the line memory
    localparam int ADDR_W = 8;
    localparam int LINE_W = 32;
    localparam int TAG_W  = 3;
    localparam int ID_W   = TAG_W + 1;   // port bit on top of the tag

    typedef logic [ADDR_W-1:0] addr_t;   // 256 lines
    typedef logic [LINE_W-1:0] line_t;
    typedef logic [TAG_W-1:0]  tag_t;

    // {port, tag}, port 0 is A and 1 is B
    typedef logic [ID_W-1:0]   id_t;

    // which port wins the next tie
    typedef enum logic {
        OWNER_A = 1'b0,
        OWNER_B = 1'b1
    } owner_e;

endpackage

// ==== rtl/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter
    import mem_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    // cache port a
    input  logic  i_a_req,
    input  logic  i_a_write,
    input  addr_t i_a_addr,
    input  line_t i_a_wdata,
    input  tag_t  i_a_tag,

    // cache port b
    input  logic  i_b_req,
    input  logic  i_b_write,
    input  addr_t i_b_addr,
    input  line_t i_b_wdata,
    input  tag_t  i_b_tag,

    input  logic  i_stall,         // pipeline cannot take anything

    output logic  o_a_grant,
    output logic  o_b_grant,

    // request into the pipeline
    output logic  o_req_valid,
    output logic  o_req_write,
    output addr_t o_req_addr,
    output line_t o_req_data,
    output id_t   o_req_id
);

    owner_e owner_q;               // priority holder for the next tie
    logic   pick_b;

    // grants are combinational, one port at most
    always_comb begin
        o_a_grant = 1'b0;
        o_b_grant = 1'b0;
        if (!i_stall) begin
            if (i_a_req && i_b_req) begin
                o_a_grant = (owner_q == OWNER_A);
                o_b_grant = (owner_q == OWNER_B);
            end else begin
                o_a_grant = i_a_req;
                o_b_grant = i_b_req;
            end
        end
    end

    // rotate only when the holder actually got served
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            owner_q <= OWNER_A;
        end else if (o_a_grant && owner_q == OWNER_A) begin
            owner_q <= OWNER_B;
        end else if (o_b_grant && owner_q == OWNER_B) begin
            owner_q <= OWNER_A;
        end
    end

    assign pick_b = o_b_grant;

    // steer the winner's fields, id gets the port bit on top
    assign o_req_valid = o_a_grant | o_b_grant;
    assign o_req_write = pick_b ? i_b_write : i_a_write;
    assign o_req_addr  = pick_b ? i_b_addr  : i_a_addr;
    assign o_req_data  = pick_b ? i_b_wdata : i_a_wdata;
    assign o_req_id    = pick_b ? {1'b1, i_b_tag} : {1'b0, i_a_tag};

endmodule

// ==== rtl/mem_pipeline.sv ====
`timescale 1ns/1ps

module mem_pipeline
    import mem_pkg::*;
#(
    parameter int STAGES = 5       // at least 3
) (
    input  logic  clk,
    input  logic  rst,

    // request from the arbiter
    input  logic  i_req_valid,
    input  logic  i_req_write,
    input  addr_t i_req_addr,
    input  line_t i_req_data,
    input  id_t   i_req_id,

    input  logic  i_full,          // response queue has no room

    output logic  o_stall,

    // read results toward the queue
    output logic  o_push,
    output line_t o_push_data,
    output id_t   o_push_id
);

    localparam int LAST  = STAGES - 1;
    localparam int PREV  = STAGES - 2;   // array read is issued here
    localparam int LINES = 1 << ADDR_W;

    line_t mem_array [LINES];

    // stage registers
    logic [STAGES-1:0] valid_q;
    logic              write_q [STAGES];
    addr_t             addr_q  [STAGES];
    line_t             data_q  [STAGES];
    id_t               id_q    [STAGES];

    line_t rd_q;                   // array value for the item in LAST
    logic  fwd_hit;
    logic  last_read;
    logic  last_write;

    assign last_read  = valid_q[LAST] && !write_q[LAST];
    assign last_write = valid_q[LAST] && write_q[LAST];

    // a read stuck at the end freezes everything
    assign o_stall = i_full && last_read;

    // trailing read of the line that a LAST write still holds
    assign fwd_hit = last_write && (addr_q[LAST] == addr_q[PREV]);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (!o_stall) begin
            valid_q <= {valid_q[STAGES-2:0], i_req_valid};
        end
    end

    // payload shifts along with the valids
    always_ff @(posedge clk) begin
        if (!o_stall) begin
            write_q[0] <= i_req_write;
            addr_q[0]  <= i_req_addr;
            data_q[0]  <= i_req_data;
            id_q[0]    <= i_req_id;
            for (int s = 1; s < STAGES; s++) begin
                write_q[s] <= write_q[s-1];
                addr_q[s]  <= addr_q[s-1];
                data_q[s]  <= data_q[s-1];
                id_q[s]    <= id_q[s-1];
            end
        end
    end

    // write commit from LAST and the registered array read from PREV
    always_ff @(posedge clk) begin
        if (!o_stall) begin
            if (last_write) begin
                mem_array[addr_q[LAST]] <= data_q[LAST];
            end
            if (fwd_hit) begin
                rd_q <= data_q[LAST];       // array not updated yet
            end else begin
                rd_q <= mem_array[addr_q[PREV]];
            end
        end
    end

    assign o_push      = last_read && !o_stall;
    assign o_push_data = rd_q;
    assign o_push_id   = id_q[LAST];

endmodule

// ==== rtl/resp_queue.sv ====
`timescale 1ns/1ps

module resp_queue
    import mem_pkg::*;
#(
    parameter int DEPTH = 4
) (
    input  logic  clk,
    input  logic  rst,

    input  logic  i_push,
    input  line_t i_push_data,
    input  id_t   i_push_id,

    input  logic  i_ack,           // sampled while o_valid is high

    output logic  o_full,

    // head of the queue, the shared response bus
    output logic  o_valid,
    output line_t o_data,
    output id_t   o_id
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    line_t data_mem [DEPTH];
    id_t   id_mem   [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic do_push;
    logic do_pop;

    assign o_full  = (count == CNT_W'(DEPTH));
    assign o_valid = (count != '0);
    assign o_data  = data_mem[rd_ptr];
    assign o_id    = id_mem[rd_ptr];

    assign do_pop  = o_valid && i_ack;
    assign do_push = i_push && (!o_full || do_pop);  // full but draining is fine

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;   // both or neither
            endcase
        end
    end

    // entry storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            data_mem[wr_ptr] <= i_push_data;
            id_mem[wr_ptr]   <= i_push_id;
        end
    end

endmodule

// ==== rtl/mem_subsystem.sv ====
`timescale 1ns/1ps

module mem_subsystem
    import mem_pkg::*;
#(
    parameter int STAGES        = 5,
    parameter int BUFFER_LENGTH = 4
) (
    input  logic  clk,
    input  logic  rst,

    input  logic  i_a_req,
    input  logic  i_a_write,
    input  addr_t i_a_addr,
    input  line_t i_a_wdata,
    input  tag_t  i_a_tag,

    input  logic  i_b_req,
    input  logic  i_b_write,
    input  addr_t i_b_addr,
    input  line_t i_b_wdata,
    input  tag_t  i_b_tag,

    input  logic  i_resp_ack,

    output logic  o_a_grant,
    output logic  o_b_grant,

    output logic  o_resp_valid,
    output line_t o_resp_data,
    output id_t   o_resp_id
);

    // arbiter to pipeline
    logic  req_valid;
    logic  req_write;
    addr_t req_addr;
    line_t req_data;
    id_t   req_id;

    logic  stall;

    // pipeline to queue
    logic  push;
    line_t push_data;
    id_t   push_id;
    logic  full;

    mem_arbiter arb0 (
        .clk         (clk),
        .rst         (rst),
        .i_a_req     (i_a_req),
        .i_a_write   (i_a_write),
        .i_a_addr    (i_a_addr),
        .i_a_wdata   (i_a_wdata),
        .i_a_tag     (i_a_tag),
        .i_b_req     (i_b_req),
        .i_b_write   (i_b_write),
        .i_b_addr    (i_b_addr),
        .i_b_wdata   (i_b_wdata),
        .i_b_tag     (i_b_tag),
        .i_stall     (stall),
        .o_a_grant   (o_a_grant),
        .o_b_grant   (o_b_grant),
        .o_req_valid (req_valid),
        .o_req_write (req_write),
        .o_req_addr  (req_addr),
        .o_req_data  (req_data),
        .o_req_id    (req_id)
    );

    mem_pipeline #(
        .STAGES (STAGES)
    ) pipe0 (
        .clk         (clk),
        .rst         (rst),
        .i_req_valid (req_valid),
        .i_req_write (req_write),
        .i_req_addr  (req_addr),
        .i_req_data  (req_data),
        .i_req_id    (req_id),
        .i_full      (full),
        .o_stall     (stall),
        .o_push      (push),
        .o_push_data (push_data),
        .o_push_id   (push_id)
    );

    resp_queue #(
        .DEPTH (BUFFER_LENGTH)
    ) rq0 (
        .clk         (clk),
        .rst         (rst),
        .i_push      (push),
        .i_push_data (push_data),
        .i_push_id   (push_id),
        .i_ack       (i_resp_ack),
        .o_full      (full),
        .o_valid     (o_resp_valid),
        .o_data      (o_resp_data),
        .o_id        (o_resp_id)
    );

endmodule

// ==== testbench/tb_mem_subsystem.sv ====
`timescale 1ns/1ps

module tb_mem_subsystem
    import mem_pkg::*;
();

    localparam int STAGES    = 5;
    localparam int DEPTH     = 4;
    localparam int MAX_REC   = 64;
    localparam int RAND_HOLD = 99;      // hold code for a random ack delay

    logic  clk;
    logic  rst;
    logic  i_a_req;
    logic  i_a_write;
    addr_t i_a_addr;
    line_t i_a_wdata;
    tag_t  i_a_tag;
    logic  i_b_req;
    logic  i_b_write;
    addr_t i_b_addr;
    line_t i_b_wdata;
    tag_t  i_b_tag;
    logic  i_resp_ack;
    logic  o_a_grant;
    logic  o_b_grant;
    logic  o_resp_valid;
    line_t o_resp_data;
    id_t   o_resp_id;

    // golden records
    int    n_rec;
    int    rec_test [MAX_REC];
    int    rec_port [MAX_REC];
    logic  rec_wr   [MAX_REC];
    addr_t rec_addr [MAX_REC];
    line_t rec_line [MAX_REC];
    tag_t  rec_tag  [MAX_REC];
    int    rec_hold [MAX_REC];

    // reference model and scoreboard, both kept in grant order
    line_t model   [256];
    line_t sb_data [$];
    id_t   sb_id   [$];
    int    sb_hold [$];
    logic  owner_b;                     // modeled tie winner

    integer seed;
    int     errors;
    int     tests_ok;
    int     tests_bad;
    int     reads_granted;
    int     resp_count;
    int     blocked;                    // cycles with a request but no grant
    int     max_hold;
    int     timeout_limit;
    int     cycle_count;

    mem_subsystem #(
        .STAGES        (STAGES),
        .BUFFER_LENGTH (DEPTH)
    ) dut0 (
        .clk          (clk),
        .rst          (rst),
        .i_a_req      (i_a_req),
        .i_a_write    (i_a_write),
        .i_a_addr     (i_a_addr),
        .i_a_wdata    (i_a_wdata),
        .i_a_tag      (i_a_tag),
        .i_b_req      (i_b_req),
        .i_b_write    (i_b_write),
        .i_b_addr     (i_b_addr),
        .i_b_wdata    (i_b_wdata),
        .i_b_tag      (i_b_tag),
        .i_resp_ack   (i_resp_ack),
        .o_a_grant    (o_a_grant),
        .o_b_grant    (o_b_grant),
        .o_resp_valid (o_resp_valid),
        .o_resp_data  (o_resp_data),
        .o_resp_id    (o_resp_id)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    task automatic load_golden();
        int    fd;
        int    code;
        int    hold_cap;
        string text;
        int    t_test;
        int    t_port;
        int    t_wr;
        addr_t t_addr;
        line_t t_line;
        tag_t  t_tag;
        int    t_hold;
        n_rec    = 0;
        max_hold = 0;
        fd = $fopen("testbench/mem_golden.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open testbench/mem_golden.txt");
        end else begin
            while (!$feof(fd) && n_rec < MAX_REC) begin
                code = $fgets(text, fd);
                if (code > 1 && text.getc(0) != "#") begin
                    code = $sscanf(text, "%d %d %d %h %h %d %d", t_test, t_port, t_wr,
                                   t_addr, t_line, t_tag, t_hold);
                    if (code == 7) begin
                        rec_test[n_rec] = t_test;
                        rec_port[n_rec] = t_port;
                        rec_wr[n_rec]   = (t_wr != 0);
                        rec_addr[n_rec] = t_addr;
                        rec_line[n_rec] = t_line;
                        rec_tag[n_rec]  = t_tag;
                        rec_hold[n_rec] = t_hold;
                        hold_cap = (t_hold == RAND_HOLD) ? 20 : t_hold;
                        if (hold_cap > max_hold) begin
                            max_hold = hold_cap;
                        end
                        n_rec++;
                    end else begin
                        errors++;
                        $display("malformed line in the golden file: %s", text);
                    end
                end
            end
            $fclose(fd);
            if (n_rec == 0) begin
                errors++;
                $display("the golden file holds no records");
            end
        end
    endtask

    // k below zero drops the request
    task automatic drive_port(input int p, input int k);
        logic  req;
        logic  wr;
        addr_t addr;
        line_t data;
        tag_t  tag;
        req  = (k >= 0);
        wr   = 1'b0;
        addr = '0;
        data = '0;
        tag  = '0;
        if (req) begin
            wr   = rec_wr[k];
            addr = rec_addr[k];
            data = rec_line[k];
            tag  = rec_tag[k];
        end
        if (p == 0) begin
            i_a_req   = req;
            i_a_write = wr;
            i_a_addr  = addr;
            i_a_wdata = data;
            i_a_tag   = tag;
        end else begin
            i_b_req   = req;
            i_b_write = wr;
            i_b_addr  = addr;
            i_b_wdata = data;
            i_b_tag   = tag;
        end
    endtask

    task automatic note_grant(input int p, input int k);
        id_t id;
        id = {p[0], rec_tag[k]};        // port bit above the tag
        if (rec_wr[k]) begin
            model[rec_addr[k]] = rec_line[k];
        end else begin
            if (model[rec_addr[k]] !== rec_line[k]) begin
                errors++;
                $display("FAIL %0t: golden line %h at %h, model holds %h", $time,
                         rec_line[k], rec_addr[k], model[rec_addr[k]]);
            end
            sb_data.push_back(model[rec_addr[k]]);
            sb_id.push_back(id);
            sb_hold.push_back(rec_hold[k]);
            reads_granted++;
        end
    endtask

    task automatic report_test(input int tnum, input int err0);
        if (errors == err0) begin
            tests_ok++;
            $display("test %0d: ok", tnum);
        end else begin
            tests_bad++;
            $display("test %0d: %0d errors", tnum, errors - err0);
        end
    endtask

    task automatic check_idle();
        int err0;
        err0 = errors;
        repeat (10) begin
            @(negedge clk);
            if (o_resp_valid || o_a_grant || o_b_grant) begin
                errors++;
                $display("FAIL %0t: activity on an idle bus after reset", $time);
            end
        end
        @(posedge clk);
        #1;
        report_test(1, err0);
    endtask

    task automatic run_test(input int tnum);
        int   qa [$];
        int   qb [$];
        int   err0;
        int   reads0;
        int   resp0;
        logic ga;
        logic gb;
        err0    = errors;
        reads0  = reads_granted;
        resp0   = resp_count;
        blocked = 0;
        for (int k = 0; k < n_rec; k++) begin
            if (rec_test[k] == tnum && rec_port[k] == 0) begin
                qa.push_back(k);
            end else if (rec_test[k] == tnum) begin
                qb.push_back(k);
            end
        end
        drive_port(0, (qa.size() > 0) ? qa[0] : -1);
        drive_port(1, (qb.size() > 0) ? qb[0] : -1);
        while (qa.size() > 0 || qb.size() > 0 || sb_data.size() > 0) begin
            @(negedge clk);             // grants are settled mid cycle
            ga = o_a_grant;
            gb = o_b_grant;
            if ((ga && !i_a_req) || (gb && !i_b_req) || (ga && gb)) begin
                errors++;
                $display("FAIL %0t: grants a=%b b=%b for requests a=%b b=%b", $time,
                         ga, gb, i_a_req, i_b_req);
            end else if (i_a_req && i_b_req && (ga || gb) && (gb != owner_b)) begin
                errors++;
                $display("FAIL %0t: tie went to port %s, round robin expects %s", $time,
                         gb ? "B" : "A", owner_b ? "B" : "A");
            end
            if ((i_a_req || i_b_req) && !ga && !gb) begin
                blocked++;
            end
            if ((ga && !owner_b) || (gb && owner_b)) begin
                owner_b = ~owner_b;     // holder served, priority moves on
            end
            if (ga && i_a_req) begin
                note_grant(0, qa[0]);
            end
            if (gb && i_b_req) begin
                note_grant(1, qb[0]);
            end
            @(posedge clk);
            #1;
            if (ga && qa.size() > 0) begin
                void'(qa.pop_front());
                drive_port(0, (qa.size() > 0) ? qa[0] : -1);
            end
            if (gb && qb.size() > 0) begin
                void'(qb.pop_front());
                drive_port(1, (qb.size() > 0) ? qb[0] : -1);
            end
        end
        // idle tail catches stray responses
        repeat (STAGES + 2) @(posedge clk);
        #1;
        if (resp_count - resp0 != reads_granted - reads0) begin
            errors++;
            $display("FAIL %0t: test %0d gave %0d responses for %0d reads", $time, tnum,
                     resp_count - resp0, reads_granted - reads0);
        end
        if (tnum == 5 && blocked == 0) begin    // back-pressure case
            errors++;
            $display("FAIL %0t: grants never stopped while ack was withheld", $time);
        end
        report_test(tnum, err0);
    endtask

    // response consumer, checks the head when it decides to ack
    initial begin : consumer
        int   hold_left;
        logic at_head;
        logic ack_next;
        hold_left  = 0;
        at_head    = 1'b0;
        i_resp_ack = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            ack_next = 1'b0;
            if (!rst && o_resp_valid) begin
                if (sb_data.size() == 0) begin
                    errors++;
                    resp_count++;
                    ack_next = 1'b1;
                    $display("unexpected response with id %h while no read is pending",
                             o_resp_id);
                end else begin
                    if (!at_head) begin
                        hold_left = (sb_hold[0] == RAND_HOLD) ? 4 + ({$random(seed)} % 16)
                                                              : sb_hold[0];
                        at_head = 1'b1;
                    end
                    if (hold_left > 0) begin
                        hold_left--;
                    end else begin
                        if (o_resp_data !== sb_data[0] || o_resp_id !== sb_id[0]) begin
                            errors++;
                            $display("FAIL %0t: response %h id %h, expected %h id %h",
                                     $time, o_resp_data, o_resp_id, sb_data[0], sb_id[0]);
                        end
                        void'(sb_data.pop_front());
                        void'(sb_id.pop_front());
                        void'(sb_hold.pop_front());
                        resp_count++;
                        at_head  = 1'b0;
                        ack_next = 1'b1;
                    end
                end
            end
            i_resp_ack = ack_next;
        end
    end

    initial begin : watchdog
        cycle_count = 0;
        wait (timeout_limit > 0);
        while (cycle_count < timeout_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run was still busy after %0d cycles", timeout_limit);
        $display("TEST FAILED");
        $finish;
    end

    initial begin : main
        seed          = 47767;
        errors        = 0;
        tests_ok      = 0;
        tests_bad     = 0;
        reads_granted = 0;
        resp_count    = 0;
        owner_b       = 1'b0;
        rst           = 1'b1;
        drive_port(0, -1);
        drive_port(1, -1);
        load_golden();
        if (n_rec > 0) begin
            timeout_limit = n_rec * (STAGES + 1 + max_hold) + 500;
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        if (n_rec > 0) begin
            check_idle();
            for (int k = 0; k < n_rec; k++) begin
                if (k == 0 || rec_test[k] != rec_test[k-1]) begin
                    run_test(rec_test[k]);
                end
            end
        end
        $display("summary: %0d tests ok, %0d tests with errors, %0d failed checks",
                 tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== testbench/mem_golden.txt ====
# test port(0=A,1=B) write(1)/read(0) addr(hex) line(hex) tag hold
# line is write data or the expected read line, hold is ack delay in cycles, 99 is random
2 0 1 10 a5a50010 1 0
2 0 1 11 a5a50011 2 0
2 0 0 10 a5a50010 3 0
2 0 0 11 a5a50011 4 2
3 0 1 20 c0ffee20 5 0
3 0 0 20 c0ffee20 6 0
3 0 1 10 5eed0010 7 0
3 0 0 10 5eed0010 0 1
4 0 1 30 0a0a0030 1 0
4 0 0 30 0a0a0030 2 0
4 0 0 41 0b0b0041 3 0
4 1 1 41 0b0b0041 4 0
4 1 1 40 0b0b0040 5 0
4 1 0 40 0b0b0040 6 0
5 0 0 10 5eed0010 0 40
5 0 0 11 a5a50011 1 0
5 0 0 30 0a0a0030 2 99
5 0 0 20 c0ffee20 3 0
5 0 0 10 5eed0010 4 0
5 1 0 40 0b0b0040 0 40
5 1 0 41 0b0b0041 1 0
5 1 0 11 a5a50011 2 0
5 1 0 30 0a0a0030 3 99
5 1 0 20 c0ffee20 4 0
6 0 1 50 11110050 1 0
6 0 0 50 11110050 2 0
6 0 1 50 22220050 3 0
6 0 0 50 22220050 4 0
6 1 1 60 66660060 5 0
6 1 0 60 66660060 6 3

// ==== sources.f ====
rtl/mem_pkg.sv
rtl/mem_arbiter.sv
rtl/mem_pipeline.sv
rtl/resp_queue.sv
rtl/mem_subsystem.sv
testbench/tb_mem_subsystem.sv

// ==== Makefile ====
TOP := tb_mem_subsystem
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --timescale 1ns/1ps -f sources.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

lint:
	verilator --lint-only -Wall rtl/mem_pkg.sv rtl/mem_arbiter.sv rtl/mem_pipeline.sv \
		rtl/resp_queue.sv rtl/mem_subsystem.sv --top-module mem_subsystem

clean:
	rm -rf obj_dir $(LOG)
